/* Makefile */
VERILATOR ?= verilator
TOP ?= notchAccelTb
FILELIST ?= notchAccel.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
RUNFLAGS ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) | tee $(LOG)
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* biquadCore.sv */
// biquad filter FSM, x and y histories, one shared multiplier, accumulate and rescale
`timescale 1ns/100ps

module biquadCore import notchPkg::*; (
	input logic clk,
	input logic arstN,
	input logic blockStart,
	input logic rxEmpty,
	input sampleT rxData, // head of receive FIFO
	output logic popRx,
	input logic txFull,
	output logic txPush,
	output sampleT txData,
	output countT calcCount
);

	coreStateT state;
	sampleT x0; // x(n)
	sampleT x1; // x(n-1)
	sampleT x2; // x(n-2)
	sampleT y1; // y(n-1), newest output
	sampleT y2; // y(n-2)
	accT acc; // running sum
	accT product; // shared multiplier output
	logic [2:0] macIdx; // term 0..4
	logic subtract; // feedback terms
	sampleT opX; // multiplier sample operand
	coeffT opC; // multiplier coefficient operand

	// term order b0 b1 b2 then a1 a2
	always_comb begin
		case (macIdx)
			3'd0: begin
				opX = x0;
				opC = coeffB0;
			end
			3'd1: begin
				opX = x1;
				opC = coeffB1;
			end
			3'd2: begin
				opX = x2;
				opC = coeffB2;
			end
			3'd3: begin
				opX = y1;
				opC = coeffA1;
			end
			default: begin
				opX = y2;
				opC = coeffA2;
			end
		endcase
	end

	assign product = opX * opC; // both signed, extended to 64 bits
	assign subtract = (macIdx >= 3'd3); // a terms are subtracted
	assign popRx = (state == coreIdle) && !rxEmpty;
	assign txPush = (state == coreEmit) && !txFull; // emit waits on a full buffer
	assign txData = y1; // result of the last scale

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= coreIdle;
			{x0, x1, x2, y1, y2} <= '0;
			acc <= '0;
			macIdx <= '0;
			calcCount <= '0;
		end else if (blockStart) begin
			state <= coreIdle; // new block starts from zero history
			{x0, x1, x2, y1, y2} <= '0;
			calcCount <= '0;
		end else begin
			case (state)
				coreIdle: if (popRx) begin
					x0 <= rxData; // shift in the new sample
					x1 <= x0;
					x2 <= x1;
					state <= coreLoad;
				end
				coreLoad: begin
					acc <= '0;
					macIdx <= '0;
					state <= coreMac;
				end
				coreMac: begin
					acc <= subtract ? acc - product : acc + product;
					macIdx <= macIdx + 1'b1;
					if (macIdx == 3'd4) state <= coreScale; // last term
				end
				coreScale: begin
					y2 <= y1;
					y1 <= sampleT'(acc >>> coeffFracBits); // drop fraction, keep low word
					state <= coreEmit;
				end
				coreEmit: if (!txFull) begin
					calcCount <= calcCount + 1'b1;
					state <= coreIdle;
				end
				default: state <= coreIdle;
			endcase
		end
	end

endmodule

/* notchAccel.f */
notchPkg.sv
sampleFifo.sv
sdReader.sv
biquadCore.sv
sdWriter.sv
notchControl.sv
notchAccel.sv
sdramModel.sv
notchAccelProps.sv
notchAccelTb.sv

/* notchAccel.sv */
// notch accelerator top: control, reader, rx and tx FIFOs, biquad core, writer
`timescale 1ns/100ps

module notchAccel import notchPkg::*; (
	input logic clk,
	input logic arstN,
	input logic start,
	input sampleT dataa,
	input countT datab,
	output logic done,
	output sampleT result,
	output addrT sdaddress,
	output logic sdread,
	output logic sdwrite,
	output sampleT sdwritedata,
	input sampleT sdreaddata,
	input logic sdreaddatavalid,
	input logic sdwaitrequest,
	input logic slaveRead,
	input logic [3:0] slaveAddress,
	output countT slaveReaddata,
	output logic irq
);

	logic blockStart, clearFifos, writesDone;
	addrT blockBase, readAddress;
	countT blockLength, rxCount, discardCount, calcCount, writeCount;
	logic rxPush, popRx, rxEmpty, rxFull; // receive side
	sampleT rxData, rxHead;
	fifoCountT rxUsed;
	logic txPush, popTx, txEmpty, txFull; // write-back side
	sampleT txData, txHead;
	fifoCountT txUsed;

	notchControl control (.clk, .arstN, .start, .dataa, .datab, .done, .result,
		.slaveRead, .slaveAddress, .slaveReaddata, .irq, .blockStart, .blockBase,
		.blockLength, .writesDone, .rxCount, .discardCount, .calcCount, .writeCount,
		.rxUsed, .txUsed, .clearFifos);

	sdReader reader (.clk, .arstN, .blockStart, .blockBase, .blockLength,
		.sdwaitrequest, .sdreaddatavalid, .sdreaddata, .sdwrite, .rxUsed, .rxFull,
		.sdread, .readAddress, .rxPush, .rxData, .rxCount, .discardCount);

	sampleFifo rxFifo (.clk, .arstN, .clear(clearFifos), .push(rxPush),
		.pushData(rxData), .pop(popRx), .popData(rxHead), .empty(rxEmpty),
		.full(rxFull), .used(rxUsed));

	biquadCore core (.clk, .arstN, .blockStart, .rxEmpty, .rxData(rxHead), .popRx,
		.txFull, .txPush, .txData, .calcCount);

	sampleFifo txFifo (.clk, .arstN, .clear(clearFifos), .push(txPush),
		.pushData(txData), .pop(popTx), .popData(txHead), .empty(txEmpty),
		.full(txFull), .used(txUsed));

	sdWriter writer (.clk, .arstN, .blockStart, .blockBase, .blockLength, .txEmpty,
		.txData(txHead), .popTx, .sdread, .readAddress, .sdwaitrequest, .sdwrite,
		.sdwritedata, .sdaddress, .writeCount, .writesDone);

endmodule

/* notchAccelProps.sv */
// concurrent checks on the accelerator bus, custom-instruction and irq ports, bound to the top
`timescale 1ns/100ps

module notchAccelProps import notchPkg::*; (
	input logic clk,
	input logic arstN,
	input logic start,
	input logic done,
	input logic sdread,
	input logic sdwrite,
	input addrT sdaddress,
	input sampleT sdwritedata,
	input logic sdwaitrequest,
	input logic irq,
	input logic blockStart
);

	int failCount = 0; // failed assertions, read by the testbench
	logic irqArmed; // a block started since irq last rose

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) irqArmed <= 1'b0;
		else if (blockStart) irqArmed <= 1'b1;
		else if (irq) irqArmed <= 1'b0; // serviced, next irq needs a new block
	end

	doneAfterStart: assert property (@(posedge clk) disable iff (!arstN) start |=> done)
		else begin
			failCount++;
			$error("done did not follow start");
		end

	doneOnlyAfterStart: assert property (@(posedge clk) disable iff (!arstN)
		done |-> $past(start))
		else begin
			failCount++;
			$error("done without a start in the previous cycle");
		end

	busExclusive: assert property (@(posedge clk) disable iff (!arstN) !(sdread && sdwrite))
		else begin
			failCount++;
			$error("sdread and sdwrite high together");
		end

	writeHeld: assert property (@(posedge clk) disable iff (!arstN) sdwrite && sdwaitrequest
		|=> sdwrite && $stable(sdaddress) && $stable(sdwritedata))
		else begin
			failCount++;
			$error("write request changed under waitrequest");
		end

	readHeld: assert property (@(posedge clk) disable iff (!arstN) sdread && sdwaitrequest
		|=> sdread && $stable(sdaddress))
		else begin
			failCount++;
			$error("read request changed under waitrequest");
		end

	irqNeedsBlock: assert property (@(posedge clk) disable iff (!arstN)
		$rose(irq) |-> irqArmed)
		else begin
			failCount++;
			$error("irq rose again without a new block");
		end

endmodule

bind notchAccel notchAccelProps props (.clk, .arstN, .start, .done, .sdread, .sdwrite,
	.sdaddress, .sdwritedata, .sdwaitrequest, .irq, .blockStart);

/* notchAccelTb.sv */
// notch accelerator testbench top: clock, reset, instruction and slave stimulus, golden filter
`timescale 1ns/100ps

module notchAccelTb import notchPkg::*; ();

	logic clk = 1'b0;
	logic arstN;
	logic start;
	sampleT dataa;
	countT datab;
	logic done;
	sampleT result;
	addrT sdaddress;
	logic sdread;
	logic sdwrite;
	sampleT sdwritedata;
	sampleT sdreaddata;
	logic sdreaddatavalid;
	logic sdwaitrequest;
	logic slaveRead;
	logic [3:0] slaveAddress;
	countT slaveReaddata;
	logic irq;

	int valueErrors = 0; // wrong values seen by the checks
	int timeouts = 0; // waits that ran out
	addrT writeAddrs [$]; // accepted write addresses in bus order
	sampleT writeWords [$]; // matching write data
	sampleT expected [$]; // golden outputs of the current block

	always #10 clk = ~clk; // 20 ns period

	notchAccel DUT (.*);
	sdramModel sdram (.*);

	always @(posedge clk) begin
		if (sdwrite && !sdwaitrequest) begin // write taken this cycle
			writeAddrs.push_back(sdaddress);
			writeWords.push_back(sdwritedata);
		end
	end

	// y(n) by the difference equation with q14 rescale and low-word truncation
	function automatic sampleT expectedOutput(input sampleT xn, input sampleT xa,
		input sampleT xb, input sampleT ya, input sampleT yb);
		longint sum;
		sum = longint'(coeffB0) * longint'(xn) + longint'(coeffB1) * longint'(xa)
			+ longint'(coeffB2) * longint'(xb) - longint'(coeffA1) * longint'(ya)
			- longint'(coeffA2) * longint'(yb);
		return sampleT'(sum >>> coeffFracBits);
	endfunction

	task automatic checkValue(input string testName, input sampleT expectedValue,
		input sampleT actualValue);
		assert (expectedValue == actualValue) else begin
			valueErrors++;
			$display("ERR %s expected 0x%08h actual 0x%08h", testName, expectedValue,
				actualValue);
		end
	endtask

	task automatic checkAtMost(input string testName, input countT limit,
		input countT actualValue);
		assert (actualValue <= limit) else begin
			valueErrors++;
			$display("ERR %s expected at most %0d actual %0d", testName, limit, actualValue);
		end
	endtask

	task automatic issueStart(input sampleT a, input countT b, output sampleT reply);
		int waitCycles;
		@(posedge clk);
		start <= 1'b1;
		dataa <= a;
		datab <= b;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		waitCycles = 0;
		while (!done && waitCycles < 4) begin
			@(negedge clk);
			waitCycles++;
		end
		if (!done) begin
			timeouts++;
			$display("timeout waiting for done after a start");
		end
		checkValue("doneLatency", '0, sampleT'(waitCycles)); // done on the next edge
		reply = result;
	endtask

	task automatic slaveQuery(input logic [3:0] addr, output countT value);
		@(posedge clk);
		slaveRead <= 1'b1;
		slaveAddress <= addr;
		@(posedge clk);
		slaveRead <= 1'b0;
		@(negedge clk);
		value = slaveReaddata; // registered one cycle after the read
	endtask

	task automatic waitIrq(input int limit);
		int cycles;
		cycles = 0;
		while (!irq && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!irq) begin
			timeouts++;
			$display("timeout waiting for irq after %0d cycles", limit);
		end
	endtask

	task automatic waitWrites(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (writeAddrs.size() < count && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (writeAddrs.size() < count) begin
			timeouts++;
			$display("timeout waiting for %0d writes after %0d cycles", count, limit);
		end
	endtask

	// random 16-bit-range samples into sdram and golden outputs from zero history
	task automatic loadBlock(input addrT base, input int length);
		logic [31:0] rnd;
		sampleT x0;
		sampleT x1;
		sampleT x2;
		sampleT y0;
		sampleT y1;
		sampleT y2;
		x1 = '0;
		x2 = '0;
		y1 = '0;
		y2 = '0;
		expected.delete();
		for (int i = 0; i < length; i++) begin
			rnd = $urandom;
			x0 = sampleT'($signed(rnd[15:0]));
			sdram.mem[int'(base[9:2]) + i] = x0;
			y0 = expectedOutput(x0, x1, x2, y1, y2);
			expected.push_back(y0);
			x2 = x1;
			x1 = x0;
			y2 = y1;
			y1 = y0;
		end
	endtask

	task automatic checkBlock(input string testName, input addrT base, input int length);
		addrT wordAddr;
		checkValue({testName, " writes"}, sampleT'(length), sampleT'(writeAddrs.size()));
		for (int i = 0; i < length && i < writeAddrs.size(); i++) begin
			wordAddr = base + addrT'(wordBytes * i);
			checkValue({testName, " address"}, sampleT'(wordAddr), sampleT'(writeAddrs[i]));
			checkValue({testName, " data"}, expected[i], writeWords[i]);
			checkValue({testName, " memory"}, expected[i], sdram.mem[int'(wordAddr[9:2])]);
		end
	endtask

	initial begin
		sampleT reply;
		countT value;
		void'($urandom(32'hc474_2c7e)); // single seed for the run
		arstN = 1'b0;
		start = 1'b0;
		dataa = '0;
		datab = '0;
		slaveRead = 1'b0;
		slaveAddress = '0;
		repeat (8) @(posedge clk);
		arstN <= 1'b1;

		issueStart('0, '0, reply); // status query while idle
		checkValue("idleQuery", statusIdle, reply);

		loadBlock(24'h000100, 40);
		issueStart(32'h0000_0100, 32'd40, reply);
		checkValue("blockStart", statusRun, reply);
		waitWrites(4, 2000); // first results written back
		issueStart(32'h0000_0100, 32'd40, reply); // progress query mid-run
		checkAtMost("progressQuery", 32'd40, countT'(reply));
		waitIrq(5000);
		checkBlock("block1", 24'h000100, 40); // all writes in before irq
		slaveQuery(4'd0, value);
		checkValue("rxCount", 32'sd40, sampleT'(value));
		checkValue("irqCleared", '0, sampleT'(irq));
		slaveQuery(4'd1, value);
		checkValue("discardCount", '0, sampleT'(value));
		slaveQuery(4'd2, value);
		checkValue("calcCount", 32'sd40, sampleT'(value));
		slaveQuery(4'd3, value);
		checkValue("writeCount", 32'sd40, sampleT'(value));
		repeat (20) @(posedge clk); // irq must stay low here

		writeAddrs.delete();
		writeWords.delete();
		loadBlock(24'h000200, 5); // second block starts from fresh history
		issueStart(32'h0000_0200, 32'd5, reply);
		checkValue("block2Start", statusRun, reply);
		waitIrq(2000);
		checkBlock("block2", 24'h000200, 5);
		slaveQuery(4'd3, value);
		checkValue("block2WriteCount", 32'sd5, sampleT'(value));

		$display("errors: value %0d, timeout %0d, assertion %0d", valueErrors, timeouts,
			DUT.props.failCount);
		if (valueErrors == 0 && timeouts == 0 && DUT.props.failCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* notchControl.sv */
// run FSM for the custom instruction, irq, status slave and block bookkeeping
`timescale 1ns/100ps

module notchControl import notchPkg::*; (
	input logic clk,
	input logic arstN,
	input logic start,
	input sampleT dataa, // block base, zero for a status query
	input countT datab, // block length in samples
	output logic done,
	output sampleT result,
	input logic slaveRead,
	input logic [3:0] slaveAddress,
	output countT slaveReaddata,
	output logic irq,
	output logic blockStart,
	output addrT blockBase,
	output countT blockLength,
	input logic writesDone,
	input countT rxCount,
	input countT discardCount,
	input countT calcCount,
	input countT writeCount,
	input fifoCountT rxUsed,
	input fifoCountT txUsed,
	output logic clearFifos
);

	runStateT state;
	logic launch; // accepted start of a block

	assign launch = (state == runIdle) && start && (dataa != '0);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= runIdle;
			done <= 1'b0;
			irq <= 1'b0;
			blockStart <= 1'b0;
			clearFifos <= 1'b0;
		end else begin
			done <= start; // every start answered next cycle
			blockStart <= launch;
			clearFifos <= launch;
			case (state)
				runIdle: if (launch) state <= runRun;
				runRun: if (writesDone) begin
					state <= runIrqWait;
					irq <= 1'b1;
				end
				runIrqWait: if (slaveRead) begin
					irq <= 1'b0; // any status read services it
					state <= runIdle;
				end
				default: state <= runIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			if (state != runIdle) result <= sampleT'(writeCount); // progress
			else if (dataa != '0) result <= statusRun;
			else result <= statusIdle;
		end
		if (launch) begin
			blockBase <= addrT'(dataa); // low 24 bits address sdram
			blockLength <= datab;
		end
		if (slaveRead) begin
			case (slaveAddress)
				4'd0: slaveReaddata <= rxCount;
				4'd1: slaveReaddata <= discardCount;
				4'd2: slaveReaddata <= calcCount;
				4'd3: slaveReaddata <= writeCount;
				4'd4: slaveReaddata <= countT'(rxUsed);
				4'd5: slaveReaddata <= countT'(txUsed);
				default: slaveReaddata <= '0; // unmapped
			endcase
		end
	end

endmodule

/* notchPkg.sv */
// sample, accumulator, coefficient, address and count types, notch constants, FSM state enums
package notchPkg;

	typedef logic signed [31:0] sampleT; // audio sample and bus data word
	typedef logic signed [63:0] accT; // mac accumulator
	typedef logic signed [15:0] coeffT; // q2.14 coefficient
	typedef logic [23:0] addrT; // sdram byte address
	typedef logic [31:0] countT; // counters and status words
	typedef logic [4:0] fifoCountT; // fill count, 0 to 16

	// notch at the default design point, scaled by 2^14
	localparam coeffT coeffA1 = -16'sd31037; // -1.89436
	localparam coeffT coeffA2 = 16'sd14971; // 0.91374
	localparam coeffT coeffB0 = 16'sd8276; // 0.50512
	localparam coeffT coeffB1 = -16'sd16384; // -1.0
	localparam coeffT coeffB2 = 16'sd8276; // same as b0

	localparam int coeffFracBits = 14; // rescale shift after mac
	localparam int fifoDepth = 16; // rx and tx buffer depth
	localparam int wordBytes = 4; // address step per sample

	localparam sampleT statusRun = 32'sd99; // reply to an accepted start
	localparam sampleT statusIdle = '1; // reply to a status query when idle

	typedef enum logic [2:0] {
		coreIdle, // wait for a sample
		coreLoad, // clear accumulator
		coreMac, // five multiply steps
		coreScale, // shift and store y
		coreEmit // push result
	} coreStateT;

	typedef enum logic [1:0] {
		runIdle, // no block active
		runRun, // block in flight
		runIrqWait // irq raised, wait for status read
	} runStateT;

endpackage

/* sampleFifo.sv */
// first-word-fall-through sample FIFO with fill count and synchronous clear
`timescale 1ns/100ps

module sampleFifo import notchPkg::*; (
	input logic clk,
	input logic arstN,
	input logic clear, // drop all contents
	input logic push,
	input sampleT pushData,
	input logic pop,
	output sampleT popData, // head word, no latency
	output logic empty,
	output logic full,
	output fifoCountT used
);

	sampleT mem [fifoDepth]; // storage
	logic [$clog2(fifoDepth)-1:0] wrPtr; // next free slot
	logic [$clog2(fifoDepth)-1:0] rdPtr; // head slot
	fifoCountT count; // words held
	logic doPush; // push that is taken
	logic doPop; // pop that is taken

	assign doPush = push && !full; // a push into a full buffer is dropped
	assign doPop = pop && !empty;
	assign empty = (count == '0);
	assign full = (count == fifoCountT'(fifoDepth));
	assign used = count;
	assign popData = mem[rdPtr]; // fall-through read

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else if (clear) begin
			wrPtr <= '0; // both pointers back to slot 0
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) wrPtr <= wrPtr + 1'b1; // wraps at depth
			if (doPop) rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // none, or both at once
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (doPush) mem[wrPtr] <= pushData; // data only, no reset
	end

endmodule

/* sdReader.sv */
// SDRAM read-address generator, outstanding-read counter, receive and discard counters
`timescale 1ns/100ps

module sdReader import notchPkg::*; (
	input logic clk,
	input logic arstN,
	input logic blockStart,
	input addrT blockBase,
	input countT blockLength,
	input logic sdwaitrequest,
	input logic sdreaddatavalid,
	input sampleT sdreaddata,
	input logic sdwrite, // writer owns the bus while high
	input fifoCountT rxUsed,
	input logic rxFull,
	output logic sdread,
	output addrT readAddress,
	output logic rxPush,
	output sampleT rxData,
	output countT rxCount,
	output countT discardCount
);

	countT reqLeft; // reads not yet accepted
	fifoCountT outstanding; // accepted, not yet pushed
	logic room; // receive space for one more read
	logic accept; // read taken by the slave

	// outstanding also covers the word sitting in the rxData stage,
	// so outstanding + rxUsed is the exact space that is promised
	assign room = ({1'b0, outstanding} + {1'b0, rxUsed}) < 6'(fifoDepth);
	assign sdread = (reqLeft != '0) && !sdwrite && room;
	assign accept = sdread && !sdwaitrequest;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			readAddress <= '0;
			reqLeft <= '0;
			outstanding <= '0;
			rxPush <= 1'b0;
			rxCount <= '0;
			discardCount <= '0;
		end else if (blockStart) begin
			readAddress <= blockBase; // reads start at the block base
			reqLeft <= blockLength;
			outstanding <= '0;
			rxPush <= 1'b0;
			rxCount <= '0;
			discardCount <= '0;
		end else begin
			if (accept) begin
				readAddress <= readAddress + addrT'(wordBytes); // next word
				reqLeft <= reqLeft - 1'b1;
			end
			case ({accept, rxPush})
				2'b10: outstanding <= outstanding + 1'b1;
				2'b01: outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
			rxPush <= sdreaddatavalid; // one stage on returned data
			if (rxPush && rxFull) discardCount <= discardCount + 1'b1; // lost word
			if (rxPush && !rxFull) rxCount <= rxCount + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (sdreaddatavalid) rxData <= sdreaddata; // payload stage
	end

endmodule

/* sdWriter.sv */
// write-back engine draining the result FIFO, owner of the shared bus address
`timescale 1ns/100ps

module sdWriter import notchPkg::*; (
	input logic clk,
	input logic arstN,
	input logic blockStart,
	input addrT blockBase,
	input countT blockLength,
	input logic txEmpty,
	input sampleT txData, // head of write-back FIFO
	output logic popTx,
	input logic sdread, // reader owns the bus while high
	input addrT readAddress,
	input logic sdwaitrequest,
	output logic sdwrite,
	output sampleT sdwritedata,
	output addrT sdaddress,
	output countT writeCount,
	output logic writesDone // one-cycle pulse after the last write
);

	addrT writeAddress; // next word to overwrite
	countT writesLeft; // writes still to complete
	logic accept; // write taken by the slave

	// one write in flight, started only on an idle bus
	assign popTx = !sdwrite && !sdread && !txEmpty && (writesLeft != '0);
	assign accept = sdwrite && !sdwaitrequest;
	assign sdaddress = sdwrite ? writeAddress : readAddress; // bus address mux

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			sdwrite <= 1'b0;
			writeAddress <= '0;
			writesLeft <= '0;
			writeCount <= '0;
			writesDone <= 1'b0;
		end else if (blockStart) begin
			sdwrite <= 1'b0;
			writeAddress <= blockBase; // results go back in place
			writesLeft <= blockLength;
			writeCount <= '0;
			writesDone <= (blockLength == '0); // empty block ends at once
		end else begin
			writesDone <= 1'b0;
			if (popTx) sdwrite <= 1'b1; // held until accepted
			if (accept) begin
				sdwrite <= 1'b0;
				writeAddress <= writeAddress + addrT'(wordBytes);
				writesLeft <= writesLeft - 1'b1;
				writeCount <= writeCount + 1'b1;
				if (writesLeft == countT'(1)) writesDone <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (popTx) sdwritedata <= txData; // stable through waitrequest
	end

endmodule

/* sdramModel.sv */
// behavioral SDRAM: word array, random waitrequest, in-order reads with 1 to 4 cycles latency
`timescale 1ns/100ps

module sdramModel import notchPkg::*; (
	input logic clk,
	input logic arstN,
	input addrT sdaddress,
	input logic sdread,
	input logic sdwrite,
	input sampleT sdwritedata,
	output sampleT sdreaddata,
	output logic sdreaddatavalid,
	output logic sdwaitrequest
);

	localparam int memWords = 256; // byte addresses 0 to 0x3fc
	sampleT mem [memWords]; // samples loaded by the testbench
	sampleT pendData [$]; // read words in flight
	int pendDue [$]; // return cycle of each word
	int cycle; // local cycle count
	int lastDue; // keeps returns in request order
	int latency;

	initial begin
		for (int i = 0; i < memWords; i++) begin
			mem[i] = sampleT'(32'hc0de_0000 ^ (i * 32'h0001_0001)); // every index bit shows
		end
	end

	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			sdwaitrequest <= 1'b0;
			sdreaddatavalid <= 1'b0;
			sdreaddata <= '0;
			cycle = 0;
			lastDue = 0;
			pendData.delete();
			pendDue.delete();
		end else begin
			cycle = cycle + 1;
			sdreaddatavalid <= 1'b0;
			if (pendDue.size() > 0 && pendDue[0] == cycle) begin // oldest word due
				sdreaddatavalid <= 1'b1;
				sdreaddata <= pendData.pop_front();
				void'(pendDue.pop_front());
			end
			if (sdread && !sdwaitrequest) begin // read accepted
				latency = 1 + int'($urandom % 32'd4);
				lastDue = (cycle + latency > lastDue) ? cycle + latency : lastDue + 1;
				pendDue.push_back(lastDue);
				pendData.push_back(mem[int'(sdaddress[9:2])]);
			end
			if (sdwrite && !sdwaitrequest) mem[int'(sdaddress[9:2])] = sdwritedata;
			sdwaitrequest <= (($urandom % 32'd4) == 32'd0); // stall about one cycle in four
		end
	end

endmodule
